// File: segre_cache.f
segre_pkg.sv
segre_mem_ifs.sv
segre_icache.sv
segre_dcache.sv
segre_mmu.sv
segre_cache_subsystem.sv
tb_main_memory.sv
tb_segre_cache_subsystem.sv

// File: Bender.yml
package:
  name: segre_cache

sources:
  - segre_pkg.sv
  - segre_mem_ifs.sv
  - segre_icache.sv
  - segre_dcache.sv
  - segre_mmu.sv
  - segre_cache_subsystem.sv
  - target: test
    files:
      - tb_main_memory.sv
      - tb_segre_cache_subsystem.sv

// File: tb_segre_cache_subsystem.sv
module tb_segre_cache_subsystem;
    import segre_pkg::*;

    localparam int unsigned IC_NUM_LANES = 4;
    localparam int unsigned DC_NUM_LANES = 8;
    localparam int unsigned NUM_FETCHES  = 200;
    localparam int unsigned NUM_DATA_OPS = 200;
    localparam int unsigned CLK_PERIOD   = 8;
    localparam logic [31:0] SEED         = 32'h2d9f7564;

    logic                        clk;
    logic                        arst_n;
    logic                        ic_req;
    logic [ADDR_SIZE-1:0]        ic_addr;
    logic                        ic_rdy;
    logic [WORD_SIZE-1:0]        ic_instr;
    logic                        dc_rd;
    logic                        dc_wr;
    logic [ADDR_SIZE-1:0]        dc_addr;
    logic [WORD_SIZE-1:0]        dc_wr_data;
    memop_data_type_e            dc_data_type;
    logic                        dc_rdy;
    logic [WORD_SIZE-1:0]        dc_rd_data;
    logic                        mm_data_rdy;
    logic [DCACHE_LANE_SIZE-1:0] mm_rd_data;
    logic [WORD_SIZE-1:0]        mm_wr_data;
    logic [ADDR_SIZE-1:0]        mm_addr;
    logic [ADDR_SIZE-1:0]        mm_wr_addr;
    logic                        mm_rd;
    logic                        mm_wr;
    memop_data_type_e            mm_wr_type;

    // Reference model of main memory
    logic [7:0]           shadow [256];
    integer               seed;
    integer               fetch_seed;
    integer               data_seed;
    logic                 wr_pending;
    logic [ADDR_SIZE-1:0] exp_wr_addr;
    logic [WORD_SIZE-1:0] exp_wr_data;
    memop_data_type_e     exp_wr_type;

    segre_cache_subsystem #(
        .IC_NUM_LANES (IC_NUM_LANES),
        .DC_NUM_LANES (DC_NUM_LANES)
    ) u_segre_cache_subsystem (
        .clk_i             (clk),
        .arst_n_i          (arst_n),
        .ic_req_i          (ic_req),
        .ic_addr_i         (ic_addr),
        .ic_rdy_o          (ic_rdy),
        .ic_instr_o        (ic_instr),
        .dc_rd_i           (dc_rd),
        .dc_wr_i           (dc_wr),
        .dc_addr_i         (dc_addr),
        .dc_wr_data_i      (dc_wr_data),
        .dc_data_type_i    (dc_data_type),
        .dc_rdy_o          (dc_rdy),
        .dc_rd_data_o      (dc_rd_data),
        .mm_data_rdy_i     (mm_data_rdy),
        .mm_rd_data_i      (mm_rd_data),
        .mm_wr_data_o      (mm_wr_data),
        .mm_addr_o         (mm_addr),
        .mm_wr_addr_o      (mm_wr_addr),
        .mm_rd_o           (mm_rd),
        .mm_wr_o           (mm_wr),
        .mm_wr_data_type_o (mm_wr_type)
    );

    tb_main_memory #(
        .SEED (SEED + 32'd2)
    ) u_main_memory (
        .clk_i      (clk),
        .rd_i       (mm_rd),
        .addr_i     (mm_addr),
        .data_rdy_o (mm_data_rdy),
        .rd_data_o  (mm_rd_data),
        .wr_i       (mm_wr),
        .wr_addr_i  (mm_wr_addr),
        .wr_data_i  (mm_wr_data),
        .wr_type_i  (mm_wr_type)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [WORD_SIZE-1:0] expected,
                              input logic [WORD_SIZE-1:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_write(
        input string                name,
        input logic [ADDR_SIZE-1:0] exp_addr,
        input logic [WORD_SIZE-1:0] exp_data,
        input memop_data_type_e     exp_type,
        input logic [ADDR_SIZE-1:0] act_addr,
        input logic [WORD_SIZE-1:0] act_data,
        input memop_data_type_e     act_type
    );
        if (act_addr !== exp_addr || act_data !== exp_data || act_type !== exp_type) begin
            $display("Fail %s: expected addr=%h data=%h type=%s, actual addr=%h data=%h type=%s",
                     name, exp_addr, exp_data, exp_type.name(),
                     act_addr, act_data, act_type.name());
            stop_on_error();
        end
    endtask

    function automatic int unsigned access_bytes(input memop_data_type_e dtype);
        case (dtype)
            BYTE:    return 1;
            HALF:    return 2;
            default: return 4;
        endcase
    endfunction

    // Little-endian read of the model, zero-extended
    function automatic logic [WORD_SIZE-1:0] shadow_read(input logic [ADDR_SIZE-1:0] addr,
                                                         input memop_data_type_e dtype);
        logic [WORD_SIZE-1:0] value;
        value = '0;
        for (int b = 0; b < access_bytes(dtype); b++) begin
            value[8*b +: 8] = shadow[addr[7:0] + b];
        end
        return value;
    endfunction

    task automatic run_fetch(input logic [ADDR_SIZE-1:0] addr);
        logic [WORD_SIZE-1:0] expected;
        expected = shadow_read(addr, WORD);
        ic_req   = 1'b1;
        ic_addr  = addr;
        do @(negedge clk); while (!ic_rdy);
        ic_req = 1'b0;
        check_word($sformatf("fetch %02h", addr[7:0]), expected, ic_instr);
    endtask

    task automatic run_load(input logic [ADDR_SIZE-1:0] addr, input memop_data_type_e dtype);
        logic [WORD_SIZE-1:0] expected;
        expected     = shadow_read(addr, dtype);
        dc_rd        = 1'b1;
        dc_addr      = addr;
        dc_data_type = dtype;
        do @(negedge clk); while (!dc_rdy);
        dc_rd = 1'b0;
        check_word($sformatf("load %s %02h", dtype.name(), addr[7:0]), expected, dc_rd_data);
    endtask

    task automatic run_store(input logic [ADDR_SIZE-1:0] addr, input logic [WORD_SIZE-1:0] data,
                             input memop_data_type_e dtype);
        exp_wr_addr = addr;
        exp_wr_data = data;
        exp_wr_type = dtype;
        wr_pending  = 1'b1;
        for (int b = 0; b < access_bytes(dtype); b++) begin
            shadow[addr[7:0] + b] = data[8*b +: 8];
        end
        dc_wr        = 1'b1;
        dc_addr      = addr;
        dc_wr_data   = data;
        dc_data_type = dtype;
        do @(negedge clk); while (!dc_rdy);
        dc_wr = 1'b0;
        if (wr_pending) begin
            $display("Store at %02h finished without a main-memory write", addr[7:0]);
            stop_on_error();
        end
    endtask

    // Fetched code lives in the lower 128 bytes
    task automatic fetch_stream();
        logic [31:0] rnd;
        for (int n = 0; n < NUM_FETCHES; n++) begin
            rnd = $random(fetch_seed);
            run_fetch({25'b0, rnd[6:2], 2'b00});
            repeat (rnd[9:8]) @(negedge clk);
        end
    endtask

    task automatic data_stream();
        logic [31:0]          rnd;
        logic [WORD_SIZE-1:0] wdata;
        logic [ADDR_SIZE-1:0] addr;
        memop_data_type_e     dtype;
        for (int n = 0; n < NUM_DATA_OPS; n++) begin
            rnd   = $random(data_seed);
            wdata = $random(data_seed);
            dtype = memop_data_type_e'(rnd[1:0] % 3);
            addr  = {24'b0, rnd[15:8]};
            if (dtype == HALF) begin
                addr[0] = 1'b0;
            end else if (dtype == WORD) begin
                addr[1:0] = 2'b00;
            end
            if (rnd[4:2] < 3) begin
                // Stores stay in the upper half, clear of the fetched code
                addr[7] = 1'b1;
                run_store(addr, wdata, dtype);
            end else begin
                run_load(addr, dtype);
            end
            repeat (rnd[6:5]) @(negedge clk);
        end
    endtask

    // Write port monitor
    always @(negedge clk) begin
        if (arst_n) begin
            if (mm_rd && mm_wr) begin
                $display("Main-memory read and write were active in the same cycle");
                stop_on_error();
            end
            if (mm_wr) begin
                if (!wr_pending) begin
                    $display("Main-memory write pulse with no store outstanding");
                    stop_on_error();
                end
                check_write("store", exp_wr_addr, exp_wr_data, exp_wr_type,
                            mm_wr_addr, mm_wr_data, mm_wr_type);
                wr_pending = 1'b0;
            end
        end
    end

    initial begin
        #((NUM_FETCHES + NUM_DATA_OPS) * 10 * CLK_PERIOD);
        $display("Watchdog expired, the DUT stopped answering requests");
        stop_on_error();
    end

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        ic_req       = 1'b0;
        ic_addr      = '0;
        dc_rd        = 1'b0;
        dc_wr        = 1'b0;
        dc_addr      = '0;
        dc_wr_data   = '0;
        dc_data_type = WORD;
        wr_pending   = 1'b0;
        seed         = SEED;
        // Independent draws for the two request streams
        fetch_seed   = seed;
        data_seed    = seed + 1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        foreach (shadow[i]) begin
            shadow[i] = u_main_memory.mem[i];
        end
        repeat (4) begin
            @(negedge clk);
            if (ic_rdy || dc_rdy || mm_rd || mm_wr) begin
                $display("Ready or memory strobe went high after reset with no request");
                stop_on_error();
            end
        end
        fork
            fetch_stream();
            data_stream();
        join
        $display("Simulation completed successfully");
        $finish;
    end

endmodule : tb_segre_cache_subsystem

// File: tb_main_memory.sv
module tb_main_memory #(
    parameter logic [31:0] SEED = 32'h2d9f7564
) (
    input  logic                                   clk_i,
    // Lane read port
    input  logic                                   rd_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0]        addr_i,
    output logic                                   data_rdy_o,
    output logic [segre_pkg::DCACHE_LANE_SIZE-1:0] rd_data_o,
    // Store port
    input  logic                                   wr_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0]        wr_addr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]        wr_data_i,
    input  segre_pkg::memop_data_type_e            wr_type_i
);
    import segre_pkg::*;

    logic [7:0]  mem [256];
    integer      seed;
    logic        busy;
    int unsigned wait_left;

    initial begin
        logic [7:0] a;
        seed       = SEED;
        busy       = 1'b0;
        wait_left  = 0;
        data_rdy_o = 1'b0;
        rd_data_o  = '0;
        // Mixed pattern so every address bit shows up in the contents
        for (int i = 0; i < 256; i++) begin
            a      = i[7:0];
            mem[i] = (a * 8'd37) ^ {a[3:0], a[7:4]} ^ 8'h5c;
        end
    end

    // Read answers after 1 to 6 cycles with one pulse carrying the whole lane
    always @(negedge clk_i) begin
        data_rdy_o <= 1'b0;
        if (busy) begin
            if (wait_left == 1) begin
                for (int i = 0; i < 16; i++) begin
                    rd_data_o[8*i +: 8] <= mem[addr_i[7:0] + i];
                end
                data_rdy_o <= 1'b1;
                busy       <= 1'b0;
            end else begin
                wait_left <= wait_left - 1;
            end
        end else if (rd_i && !data_rdy_o) begin
            busy      <= 1'b1;
            wait_left <= 1 + ($unsigned($random(seed)) % 6);
        end
    end

    // Write lands in the cycle of the pulse and is sized by the data type
    always @(posedge clk_i) begin
        if (wr_i) begin
            case (wr_type_i)
                BYTE: mem[wr_addr_i[7:0]] = wr_data_i[7:0];
                HALF: begin
                    mem[wr_addr_i[7:0]]     = wr_data_i[7:0];
                    mem[wr_addr_i[7:0] + 1] = wr_data_i[15:8];
                end
                default: begin
                    for (int b = 0; b < 4; b++) begin
                        mem[wr_addr_i[7:0] + b] = wr_data_i[8*b +: 8];
                    end
                end
            endcase
        end
    end

endmodule : tb_main_memory

// File: segre_cache_subsystem.sv
module segre_cache_subsystem #(
    parameter int unsigned IC_NUM_LANES = 4,
    parameter int unsigned DC_NUM_LANES = 8
) (
    input  logic                                   clk_i,
    input  logic                                   arst_n_i,
    // Instruction side
    input  logic                                   ic_req_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0]        ic_addr_i,
    output logic                                   ic_rdy_o,
    output logic [segre_pkg::WORD_SIZE-1:0]        ic_instr_o,
    // Data side
    input  logic                                   dc_rd_i,
    input  logic                                   dc_wr_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0]        dc_addr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]        dc_wr_data_i,
    input  segre_pkg::memop_data_type_e            dc_data_type_i,
    output logic                                   dc_rdy_o,
    output logic [segre_pkg::WORD_SIZE-1:0]        dc_rd_data_o,
    // Main memory
    input  logic                                   mm_data_rdy_i,
    input  logic [segre_pkg::DCACHE_LANE_SIZE-1:0] mm_rd_data_i,
    output logic [segre_pkg::WORD_SIZE-1:0]        mm_wr_data_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]        mm_addr_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]        mm_wr_addr_o,
    output logic                                   mm_rd_o,
    output logic                                   mm_wr_o,
    output segre_pkg::memop_data_type_e            mm_wr_data_type_o
);

    segre_refill_if ic_refill ();
    segre_refill_if dc_refill ();
    segre_store_if  dc_store ();

    segre_icache #(
        .IC_NUM_LANES (IC_NUM_LANES)
    ) u_icache (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (ic_req_i),
        .addr_i   (ic_addr_i),
        .rdy_o    (ic_rdy_o),
        .instr_o  (ic_instr_o),
        .refill   (ic_refill)
    );

    segre_dcache #(
        .DC_NUM_LANES (DC_NUM_LANES)
    ) u_dcache (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .rd_i        (dc_rd_i),
        .wr_i        (dc_wr_i),
        .addr_i      (dc_addr_i),
        .wr_data_i   (dc_wr_data_i),
        .data_type_i (dc_data_type_i),
        .rdy_o       (dc_rdy_o),
        .rd_data_o   (dc_rd_data_o),
        .refill      (dc_refill),
        .store       (dc_store)
    );

    // Single main-memory port shared by both caches
    segre_mmu u_mmu (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .ic_refill         (ic_refill),
        .dc_refill         (dc_refill),
        .dc_store          (dc_store),
        .mm_data_rdy_i     (mm_data_rdy_i),
        .mm_rd_data_i      (mm_rd_data_i),
        .mm_rd_o           (mm_rd_o),
        .mm_wr_o           (mm_wr_o),
        .mm_addr_o         (mm_addr_o),
        .mm_wr_addr_o      (mm_wr_addr_o),
        .mm_wr_data_o      (mm_wr_data_o),
        .mm_wr_data_type_o (mm_wr_data_type_o)
    );

endmodule : segre_cache_subsystem

// File: segre_mmu.sv
module segre_mmu (
    input  logic                                   clk_i,
    input  logic                                   arst_n_i,
    // Cache side
    segre_refill_if.mmu                            ic_refill,
    segre_refill_if.mmu                            dc_refill,
    segre_store_if.mmu                             dc_store,
    // Main memory
    input  logic                                   mm_data_rdy_i,
    input  logic [segre_pkg::DCACHE_LANE_SIZE-1:0] mm_rd_data_i,
    output logic                                   mm_rd_o,
    output logic                                   mm_wr_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]        mm_addr_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]        mm_wr_addr_o,
    output logic [segre_pkg::WORD_SIZE-1:0]        mm_wr_data_o,
    output segre_pkg::memop_data_type_e            mm_wr_data_type_o
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_RD_IC = 2'd1;
    localparam logic [1:0] ST_RD_DC = 2'd2;

    logic [1:0] state_q;
    logic       wr_grant;

    // Skip the st_req still high in the cycle of its own write
    assign wr_grant = (state_q == ST_IDLE) && dc_store.st_req && !mm_wr_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            mm_wr_o <= 1'b0;
        end else begin
            mm_wr_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    // Data cache first
                    if (wr_grant) begin
                        mm_wr_o <= 1'b1;
                    end else if (dc_refill.miss) begin
                        state_q <= ST_RD_DC;
                    end else if (ic_refill.miss) begin
                        state_q <= ST_RD_IC;
                    end
                end
                ST_RD_IC, ST_RD_DC: begin
                    if (mm_data_rdy_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Read channel
    assign mm_rd_o   = (state_q == ST_RD_IC) || (state_q == ST_RD_DC);
    assign mm_addr_o = (state_q == ST_RD_DC) ? dc_refill.addr : ic_refill.addr;

    // Returned lane goes to the owner of the read
    assign ic_refill.fill_rdy  = mm_data_rdy_i && (state_q == ST_RD_IC);
    assign dc_refill.fill_rdy  = mm_data_rdy_i && (state_q == ST_RD_DC);
    assign ic_refill.fill_data = mm_rd_data_i;
    assign dc_refill.fill_data = mm_rd_data_i;

    // Write channel fields are held by the data cache until st_done
    assign mm_wr_addr_o      = dc_store.st_addr;
    assign mm_wr_data_o      = dc_store.st_data;
    assign mm_wr_data_type_o = dc_store.st_type;
    assign dc_store.st_done  = mm_wr_o;

    a_rdy_in_read: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) mm_data_rdy_i |-> mm_rd_o
    );

endmodule : segre_mmu

// File: segre_dcache.sv
module segre_dcache #(
    parameter int unsigned DC_NUM_LANES = 8
) (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    // Load/store side
    input  logic                            rd_i,
    input  logic                            wr_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0] addr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] wr_data_i,
    input  segre_pkg::memop_data_type_e     data_type_i,
    output logic                            rdy_o,
    output logic [segre_pkg::WORD_SIZE-1:0] rd_data_o,
    // MMU side
    segre_refill_if.cache                   refill,
    segre_store_if.cache                    store
);
    import segre_pkg::*;

    localparam int unsigned IDX_BITS = $clog2(DC_NUM_LANES);
    localparam int unsigned TAG_BITS = ADDR_SIZE - LANE_OFFSET_BITS - IDX_BITS;

    lane_t                   lanes [DC_NUM_LANES];
    logic [TAG_BITS-1:0]     tags  [DC_NUM_LANES];
    logic [DC_NUM_LANES-1:0] valid;

    logic [IDX_BITS-1:0]         idx;
    logic [TAG_BITS-1:0]         tag;
    logic [LANE_OFFSET_BITS-1:0] offset;
    logic                        hit;
    logic                        sample;

    // Pick byte, half or word out of a lane, zero-extended
    function automatic logic [WORD_SIZE-1:0] load_extract(
        lane_t                       lane,
        logic [LANE_OFFSET_BITS-1:0] off,
        memop_data_type_e            dtype
    );
        case (dtype)
            BYTE:    return {24'b0, lane.bytes[off]};
            HALF:    return {16'b0, lane.bytes[off | 4'd1], lane.bytes[off]};
            default: return lane.words[off[LANE_OFFSET_BITS-1:2]];
        endcase
    endfunction

    // Patch store data into a lane
    function automatic lane_t store_merge(
        lane_t                       lane,
        logic [LANE_OFFSET_BITS-1:0] off,
        memop_data_type_e            dtype,
        logic [WORD_SIZE-1:0]        data
    );
        lane_t res;
        res = lane;
        case (dtype)
            BYTE: res.bytes[off] = data[7:0];
            HALF: begin
                res.bytes[off]        = data[7:0];
                res.bytes[off | 4'd1] = data[15:8];
            end
            default: res.words[off[LANE_OFFSET_BITS-1:2]] = data;
        endcase
        return res;
    endfunction

    assign idx    = addr_i[LANE_OFFSET_BITS +: IDX_BITS];
    assign tag    = addr_i[ADDR_SIZE-1 -: TAG_BITS];
    assign offset = addr_i[LANE_OFFSET_BITS-1:0];
    assign hit    = valid[idx] && (tags[idx] == tag);

    // Accept a new access only when nothing is outstanding
    assign sample = (rd_i || wr_i) && !refill.miss && !store.st_req && !rdy_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdy_o        <= 1'b0;
            refill.miss  <= 1'b0;
            store.st_req <= 1'b0;
            valid        <= '0;
        end else begin
            rdy_o <= 1'b0;
            if (sample && rd_i) begin
                if (hit) begin
                    rdy_o <= 1'b1;
                end else begin
                    refill.miss <= 1'b1;
                end
            end
            // Every store goes through to memory
            if (sample && wr_i) begin
                store.st_req <= 1'b1;
            end
            if (refill.fill_rdy) begin
                refill.miss <= 1'b0;
                valid[idx]  <= 1'b1;
                rdy_o       <= 1'b1;
            end
            if (store.st_done) begin
                store.st_req <= 1'b0;
                rdy_o        <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sample && rd_i && hit) begin
            rd_data_o <= load_extract(lanes[idx], offset, data_type_i);
        end
        if (sample && rd_i && !hit) begin
            refill.addr <= {addr_i[ADDR_SIZE-1:LANE_OFFSET_BITS], {LANE_OFFSET_BITS{1'b0}}};
        end
        // No write allocate, so a store miss leaves the lanes alone
        if (sample && wr_i) begin
            store.st_addr <= addr_i;
            store.st_data <= wr_data_i;
            store.st_type <= data_type_i;
            if (hit) begin
                lanes[idx] <= store_merge(lanes[idx], offset, data_type_i, wr_data_i);
            end
        end
        if (refill.fill_rdy) begin
            lanes[idx] <= refill.fill_data;
            tags[idx]  <= tag;
            rd_data_o  <= load_extract(refill.fill_data, offset, data_type_i);
        end
    end

    a_rd_wr_excl: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) !(rd_i && wr_i)
    );

    // Accesses never cross a lane
    a_aligned: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (rd_i || wr_i) |-> (data_type_i != HALF || !addr_i[0]) &&
                           (data_type_i != WORD || addr_i[1:0] == 2'b00)
    );

endmodule : segre_dcache

// File: segre_icache.sv
module segre_icache #(
    parameter int unsigned IC_NUM_LANES = 4
) (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    // Fetch side
    input  logic                           req_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0] addr_i,
    output logic                           rdy_o,
    output logic [segre_pkg::WORD_SIZE-1:0] instr_o,
    // Refill path to the MMU
    segre_refill_if.cache                  refill
);
    import segre_pkg::*;

    localparam int unsigned IDX_BITS = $clog2(IC_NUM_LANES);
    localparam int unsigned TAG_BITS = ADDR_SIZE - LANE_OFFSET_BITS - IDX_BITS;

    lane_t                     lanes [IC_NUM_LANES];
    logic [TAG_BITS-1:0]       tags  [IC_NUM_LANES];
    logic [IC_NUM_LANES-1:0]   valid;

    logic [IDX_BITS-1:0]           idx;
    logic [TAG_BITS-1:0]           tag;
    logic [LANE_OFFSET_BITS-3:0]   word_sel;
    logic                          hit;
    logic                          lookup;

    // Address split
    assign idx      = addr_i[LANE_OFFSET_BITS +: IDX_BITS];
    assign tag      = addr_i[ADDR_SIZE-1 -: TAG_BITS];
    assign word_sel = addr_i[LANE_OFFSET_BITS-1:2];

    assign hit    = valid[idx] && (tags[idx] == tag);
    // No new lookup while a miss is open or the answer is going out
    assign lookup = req_i && !refill.miss && !rdy_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdy_o       <= 1'b0;
            refill.miss <= 1'b0;
            valid       <= '0;
        end else begin
            rdy_o <= 1'b0;
            if (refill.miss) begin
                if (refill.fill_rdy) begin
                    refill.miss <= 1'b0;
                    valid[idx]  <= 1'b1;
                    rdy_o       <= 1'b1;
                end
            end else if (lookup) begin
                if (hit) begin
                    rdy_o <= 1'b1;
                end else begin
                    refill.miss <= 1'b1;
                end
            end
        end
    end

    // Lane storage and returned word
    always_ff @(posedge clk_i) begin
        if (lookup && hit) begin
            instr_o <= lanes[idx].words[word_sel];
        end
        if (lookup && !hit) begin
            refill.addr <= {addr_i[ADDR_SIZE-1:LANE_OFFSET_BITS], {LANE_OFFSET_BITS{1'b0}}};
        end
        if (refill.fill_rdy) begin
            lanes[idx] <= refill.fill_data;
            tags[idx]  <= tag;
            instr_o    <= refill.fill_data.words[word_sel];
        end
    end

    // MMU answers only an open miss
    a_fill_only_on_miss: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) refill.fill_rdy |-> refill.miss
    );

endmodule : segre_icache

// File: segre_mem_ifs.sv
interface segre_refill_if;
    import segre_pkg::*;

    // Miss request, level held until the fill
    logic                 miss;
    logic [ADDR_SIZE-1:0] addr;
    // Fill answer, one-cycle pulse with the lane
    logic                 fill_rdy;
    lane_t                fill_data;

    modport cache (
        output miss,
        output addr,
        input  fill_rdy,
        input  fill_data
    );

    modport mmu (
        input  miss,
        input  addr,
        output fill_rdy,
        output fill_data
    );

endinterface : segre_refill_if

interface segre_store_if;
    import segre_pkg::*;

    // Store request, fields stable until st_done
    logic                 st_req;
    logic [ADDR_SIZE-1:0] st_addr;
    logic [WORD_SIZE-1:0] st_data;
    memop_data_type_e     st_type;
    logic                 st_done;

    modport cache (
        output st_req,
        output st_addr,
        output st_data,
        output st_type,
        input  st_done
    );

    modport mmu (
        input  st_req,
        input  st_addr,
        input  st_data,
        input  st_type,
        output st_done
    );

endinterface : segre_store_if

// File: segre_pkg.sv
package segre_pkg;

    // Datapath sizes
    localparam int unsigned WORD_SIZE        = 32;
    localparam int unsigned ADDR_SIZE        = 32;
    localparam int unsigned DCACHE_LANE_SIZE = 128;
    localparam int unsigned LANE_OFFSET_BITS = 4;

    // Views of one lane
    localparam int unsigned LANE_WORDS = DCACHE_LANE_SIZE / WORD_SIZE;
    localparam int unsigned LANE_BYTES = DCACHE_LANE_SIZE / 8;

    // Access size of a load or store
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memop_data_type_e;

    // One cache lane, read as words or patched as bytes
    typedef union packed {
        logic [LANE_WORDS-1:0][WORD_SIZE-1:0] words;
        logic [LANE_BYTES-1:0][7:0]           bytes;
    } lane_t;

endpackage : segre_pkg
